// ==== hw/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Byte address and data word
`define DCACHE_ADDR_W   32
`define DCACHE_WORD_W   32

// Line geometry, direct mapped with 16 lines of 2 words
`define DCACHE_WORDS    2
`define DCACHE_INDEX_W  4
`define DCACHE_OFFSET_W 3

// Address bits left above index and offset
`define DCACHE_TAG_W    (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

// ==== hw/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    // Byte address, taken raw from the core or split into cache fields
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        struct packed {
            logic [`DCACHE_TAG_W-1:0]                          tag;
            logic [`DCACHE_INDEX_W-1:0]                        index;
            logic [$clog2(`DCACHE_WORDS)-1:0]                  word_sel;
            logic [`DCACHE_OFFSET_W-$clog2(`DCACHE_WORDS)-1:0] byte_off;
        } fields;
    } cache_addr_u;

    // One full line, word 0 in the low half
    typedef logic [`DCACHE_WORDS-1:0][`DCACHE_WORD_W-1:0] line_data_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
        line_data_t               data;
    } cache_line_t;

    // Miss handler FSM states
    typedef enum logic [1:0] {
        MH_IDLE,
        MH_WRITEBACK,
        MH_FETCH
    } mh_state_e;

endpackage

// ==== hw/dcache_if.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

// Pipeline to line storage
interface array_if;
    import dcache_pkg::*;

    // Read side, rd_line follows rd_en by one cycle
    logic                       rd_en;
    logic [`DCACHE_INDEX_W-1:0] rd_index;
    cache_line_t                rd_line;

    // Write side
    logic                       wr_en;
    logic [`DCACHE_INDEX_W-1:0] wr_index;
    cache_line_t                wr_line;

    modport reader (output rd_en, rd_index, input rd_line);
    modport writer (output wr_en, wr_index, wr_line);
    modport array  (input rd_en, rd_index, wr_en, wr_index, wr_line, output rd_line);
endinterface

// Tag check to miss handler
interface miss_if;
    import dcache_pkg::*;

    logic        miss_start;
    logic        victim_dirty;
    cache_addr_u victim_addr;
    line_data_t  victim_data;
    cache_addr_u fill_addr;

    // Refill result, fill_done is a single pulse
    logic        fill_done;
    line_data_t  fill_data;

    modport requester (
        output miss_start, victim_dirty, victim_addr, victim_data, fill_addr,
        input  fill_done, fill_data
    );
    modport handler (
        input  miss_start, victim_dirty, victim_addr, victim_data, fill_addr,
        output fill_done, fill_data
    );
endinterface

// ==== hw/line_array.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module line_array (
    input  logic   clk_i,
    input  logic   rst_i,
    array_if.array arr_if
);
    import dcache_pkg::*;

    logic [(1 << `DCACHE_INDEX_W)-1:0] valid_q;
    cache_line_t                       lines_q [(1 << `DCACHE_INDEX_W)];
    cache_line_t                       rd_line_q;
    logic                              fwd;

    // Same index written and read at one edge
    assign fwd = arr_if.wr_en && (arr_if.wr_index == arr_if.rd_index);

    // Valid bit per line
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (arr_if.wr_en) begin
            valid_q[arr_if.wr_index] <= arr_if.wr_line.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr_if.wr_en) begin
            lines_q[arr_if.wr_index] <= arr_if.wr_line;
        end
    end

    // ------------------------------
    // Registered read, write first
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (arr_if.rd_en) begin
            if (fwd) begin
                rd_line_q <= arr_if.wr_line;
            end else begin
                rd_line_q       <= lines_q[arr_if.rd_index];
                rd_line_q.valid <= valid_q[arr_if.rd_index];
            end
        end
    end

    assign arr_if.rd_line = rd_line_q;
endmodule

// ==== hw/lookup_stage.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module lookup_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  logic                      we_i,
    input  dcache_pkg::cache_addr_u   addr_i,
    input  logic [`DCACHE_WORD_W-1:0] wdata_i,
    input  logic                      stall_i,
    input  logic                      replay_i,
    output logic                      gnt_o,
    array_if.reader                   rd,
    output logic                      s1_valid_o,
    output logic                      s1_we_o,
    output dcache_pkg::cache_addr_u   s1_addr_o,
    output logic [`DCACHE_WORD_W-1:0] s1_wdata_o
);
    logic accept;

    // No new request while a miss is outstanding
    assign gnt_o  = !stall_i;
    assign accept = req_i && gnt_o;

    // ------------------------------
    // Array read
    // ------------------------------
    // Incoming index normally, held index again once the refill is written
    assign rd.rd_en    = accept || (replay_i && s1_valid_o);
    assign rd.rd_index = replay_i ? s1_addr_o.fields.index : addr_i.fields.index;

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else if (gnt_o) begin
            s1_valid_o <= req_i;
        end
    end

    // Request payload, lines up with the registered line
    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_we_o    <= we_i;
            s1_addr_o  <= addr_i;
            s1_wdata_o <= wdata_i;
        end
    end
endmodule

// ==== hw/tag_check_stage.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_check_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      s1_valid_i,
    input  logic                      s1_we_i,
    input  dcache_pkg::cache_addr_u   s1_addr_i,
    input  logic [`DCACHE_WORD_W-1:0] s1_wdata_i,
    array_if.writer                   wr,
    input  dcache_pkg::cache_line_t   rd_line_i,
    miss_if.requester                 mreq,
    output logic                      stall_o,
    output logic                      replay_o,
    output logic                      resp_valid_o,
    output logic [`DCACHE_WORD_W-1:0] rdata_o
);
    import dcache_pkg::*;

    logic                      check;
    logic                      hit;
    logic                      miss;
    logic                      fill;
    logic                      busy_q;
    logic                      miss_start_q;
    logic                      resp_q;
    logic [`DCACHE_WORD_W-1:0] rdata_q;
    cache_line_t               hit_line;
    cache_line_t               fill_line;
    // Request that missed, with the line it displaces
    logic                      miss_we_q;
    cache_addr_u               miss_addr_q;
    logic [`DCACHE_WORD_W-1:0] miss_wdata_q;
    cache_line_t               victim_q;

    // Stage 1 item is ignored while a refill is pending
    assign check = s1_valid_i && !busy_q;
    assign hit   = rd_line_i.valid && (rd_line_i.tag == s1_addr_i.fields.tag);
    assign miss  = check && !hit;
    assign fill  = busy_q && mreq.fill_done;

    // ------------------------------
    // Line updates
    // ------------------------------
    always_comb begin
        hit_line       = rd_line_i;
        hit_line.dirty = 1'b1;
        hit_line.data[s1_addr_i.fields.word_sel] = s1_wdata_i;
    end

    // Refilled line, store word merged in for a store miss
    always_comb begin
        fill_line.valid = 1'b1;
        fill_line.dirty = miss_we_q;
        fill_line.tag   = miss_addr_q.fields.tag;
        fill_line.data  = mreq.fill_data;
        if (miss_we_q) begin
            fill_line.data[miss_addr_q.fields.word_sel] = miss_wdata_q;
        end
    end

    assign wr.wr_en    = fill || (check && hit && s1_we_i);
    assign wr.wr_index = fill ? miss_addr_q.fields.index : s1_addr_i.fields.index;
    assign wr.wr_line  = fill ? fill_line : hit_line;

    // ------------------------------
    // Control and capture
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            miss_start_q <= 1'b0;
            resp_q       <= 1'b0;
        end else begin
            miss_start_q <= miss;
            resp_q       <= check && hit;
            if (miss) begin
                busy_q <= 1'b1;
            end else if (fill) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (check && hit) begin
            rdata_q <= rd_line_i.data[s1_addr_i.fields.word_sel];
        end
        if (miss) begin
            miss_we_q    <= s1_we_i;
            miss_addr_q  <= s1_addr_i;
            miss_wdata_q <= s1_wdata_i;
            victim_q     <= rd_line_i;
        end
    end

    // Line aligned addresses for the memory side
    always_comb begin
        mreq.fill_addr                 = miss_addr_q;
        mreq.fill_addr.fields.word_sel = '0;
        mreq.fill_addr.fields.byte_off = '0;
        mreq.victim_addr               = '0;
        mreq.victim_addr.fields.tag    = victim_q.tag;
        mreq.victim_addr.fields.index  = miss_addr_q.fields.index;
    end

    assign mreq.miss_start   = miss_start_q;
    assign mreq.victim_dirty = victim_q.valid && victim_q.dirty;
    assign mreq.victim_data  = victim_q.data;

    assign stall_o      = busy_q;
    assign replay_o     = fill;
    // A miss answers in its refill cycle, hits one cycle after the check
    assign resp_valid_o = resp_q || fill;
    assign rdata_o      = fill ? fill_line.data[miss_addr_q.fields.word_sel] : rdata_q;
endmodule

// ==== hw/miss_handler.sv ====
`timescale 1ns/1ps

module miss_handler (
    input  logic                    clk_i,
    input  logic                    rst_i,
    miss_if.handler                 mreq,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output dcache_pkg::cache_addr_u mem_addr_o,
    output dcache_pkg::line_data_t  mem_wdata_o,
    input  logic                    mem_ack_i,
    input  dcache_pkg::line_data_t  mem_rdata_i
);
    import dcache_pkg::*;

    mh_state_e  state_q;
    mh_state_e  state_d;
    logic       fill_done_q;
    line_data_t fill_data_q;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            MH_IDLE: begin
                // Clean or invalid victim goes straight to the fetch
                if (mreq.miss_start) begin
                    state_d = mreq.victim_dirty ? MH_WRITEBACK : MH_FETCH;
                end
            end
            MH_WRITEBACK: begin
                if (mem_ack_i) begin
                    state_d = MH_FETCH;
                end
            end
            MH_FETCH: begin
                if (mem_ack_i) begin
                    state_d = MH_IDLE;
                end
            end
            default: begin
                state_d = MH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= MH_IDLE;
            fill_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            fill_done_q <= (state_q == MH_FETCH) && mem_ack_i;
        end
    end

    // Fetched line, returned the cycle after its ack
    always_ff @(posedge clk_i) begin
        if ((state_q == MH_FETCH) && mem_ack_i) begin
            fill_data_q <= mem_rdata_i;
        end
    end

    // ------------------------------
    // Memory port
    // ------------------------------
    // Request held from state alone, fields held by the requester
    assign mem_req_o   = (state_q != MH_IDLE);
    assign mem_we_o    = (state_q == MH_WRITEBACK);
    assign mem_addr_o  = mem_we_o ? mreq.victim_addr : mreq.fill_addr;
    assign mem_wdata_o = mreq.victim_data;

    assign mreq.fill_done = fill_done_q;
    assign mreq.fill_data = fill_data_q;
endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Core port
    input  logic                      req_i,
    input  logic                      we_i,
    input  dcache_pkg::cache_addr_u   addr_i,
    input  logic [`DCACHE_WORD_W-1:0] wdata_i,
    output logic                      gnt_o,
    output logic                      resp_valid_o,
    output logic [`DCACHE_WORD_W-1:0] rdata_o,
    // Memory port, one line per beat
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output dcache_pkg::cache_addr_u   mem_addr_o,
    output dcache_pkg::line_data_t    mem_wdata_o,
    input  logic                      mem_ack_i,
    input  dcache_pkg::line_data_t    mem_rdata_i
);
    import dcache_pkg::*;

    array_if arr_if ();
    miss_if  miss_bus ();

    logic                      stall;
    logic                      replay;
    logic                      s1_valid;
    logic                      s1_we;
    cache_addr_u               s1_addr;
    logic [`DCACHE_WORD_W-1:0] s1_wdata;

    // ------------------------------
    // Pipeline
    // ------------------------------
    lookup_stage i_lookup (
        .clk_i      ( clk_i    ),
        .rst_i      ( rst_i    ),
        .req_i      ( req_i    ),
        .we_i       ( we_i     ),
        .addr_i     ( addr_i   ),
        .wdata_i    ( wdata_i  ),
        .stall_i    ( stall    ),
        .replay_i   ( replay   ),
        .gnt_o      ( gnt_o    ),
        .rd         ( arr_if   ),
        .s1_valid_o ( s1_valid ),
        .s1_we_o    ( s1_we    ),
        .s1_addr_o  ( s1_addr  ),
        .s1_wdata_o ( s1_wdata )
    );

    tag_check_stage i_tag_check (
        .clk_i        ( clk_i          ),
        .rst_i        ( rst_i          ),
        .s1_valid_i   ( s1_valid       ),
        .s1_we_i      ( s1_we          ),
        .s1_addr_i    ( s1_addr        ),
        .s1_wdata_i   ( s1_wdata       ),
        .wr           ( arr_if         ),
        .rd_line_i    ( arr_if.rd_line ),
        .mreq         ( miss_bus       ),
        .stall_o      ( stall          ),
        .replay_o     ( replay         ),
        .resp_valid_o ( resp_valid_o   ),
        .rdata_o      ( rdata_o        )
    );

    // ------------------------------
    // Storage and refill
    // ------------------------------
    line_array i_line_array (
        .clk_i  ( clk_i  ),
        .rst_i  ( rst_i  ),
        .arr_if ( arr_if )
    );

    miss_handler i_miss_handler (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .mreq        ( miss_bus    ),
        .mem_req_o   ( mem_req_o   ),
        .mem_we_o    ( mem_we_o    ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_ack_i   ( mem_ack_i   ),
        .mem_rdata_i ( mem_rdata_i )
    );
endmodule

// ==== testbench/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    req_i,
    input logic                    gnt_o,
    input logic                    resp_valid_o,
    input logic                    mem_req_o,
    input logic                    mem_we_o,
    input dcache_pkg::cache_addr_u mem_addr_o,
    input dcache_pkg::line_data_t  mem_wdata_o,
    input logic                    mem_ack_i
);
    int unsigned assert_fails = 0;

    // Memory request and its fields held until the ack
    mem_req_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o)
    ) else begin
        $error("Memory request dropped or changed before its ack");
        assert_fails++;
    end

    // No grant while the miss handler is busy
    no_gnt_in_miss: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_req_o |-> !gnt_o
    ) else begin
        $error("Grant given while a miss is outstanding");
        assert_fails++;
    end

    // Hit answers two edges after acceptance
    hit_latency: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (req_i && gnt_o) ##1 gnt_o ##1 gnt_o |-> resp_valid_o
    ) else begin
        $error("Hit response missing two cycles after acceptance");
        assert_fails++;
    end
endmodule

bind dcache_top dcache_props props_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_i        ( req_i        ),
    .gnt_o        ( gnt_o        ),
    .resp_valid_o ( resp_valid_o ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_ack_i    ( mem_ack_i    )
);

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    logic                      clk_i;
    logic                      rst_i;
    logic                      req_i;
    logic                      we_i;
    cache_addr_u               addr_i;
    logic [`DCACHE_WORD_W-1:0] wdata_i;
    logic                      gnt_o;
    logic                      resp_valid_o;
    logic [`DCACHE_WORD_W-1:0] rdata_o;
    logic                      mem_req_o;
    logic                      mem_we_o;
    cache_addr_u               mem_addr_o;
    line_data_t                mem_wdata_o;
    logic                      mem_ack_i;
    line_data_t                mem_rdata_i;

    // Trace operations and responses still owed by the DUT
    byte                       op_kind [$];
    logic [`DCACHE_ADDR_W-1:0] op_addr [$];
    logic [`DCACHE_WORD_W-1:0] op_data [$];
    bit                        exp_is_load [$];
    logic [`DCACHE_WORD_W-1:0] exp_data [$];
    string                     exp_name [$];

    // Backing store, untouched words read back their own address
    logic [`DCACHE_WORD_W-1:0] mem_words [logic [`DCACHE_ADDR_W-1:0]];

    int unsigned wb_count    = 0;
    int unsigned word_errs   = 0;
    int unsigned count_errs  = 0;
    int unsigned addr_errs   = 0;
    int unsigned other_errs  = 0;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;

    dcache_top dut_i (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .req_i        ( req_i        ),
        .we_i         ( we_i         ),
        .addr_i       ( addr_i       ),
        .wdata_i      ( wdata_i      ),
        .gnt_o        ( gnt_o        ),
        .resp_valid_o ( resp_valid_o ),
        .rdata_o      ( rdata_o      ),
        .mem_req_o    ( mem_req_o    ),
        .mem_we_o     ( mem_we_o     ),
        .mem_addr_o   ( mem_addr_o   ),
        .mem_wdata_o  ( mem_wdata_o  ),
        .mem_ack_i    ( mem_ack_i    ),
        .mem_rdata_i  ( mem_rdata_i  )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input logic [`DCACHE_WORD_W-1:0] exp,
                              input logic [`DCACHE_WORD_W-1:0] act);
        if (exp !== act) begin
            word_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
        if (exp != act) begin
            count_errs++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u exp, input cache_addr_u act);
        if (exp.raw !== act.raw) begin
            addr_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp.raw, act.raw);
        end
    endtask

    function automatic logic [`DCACHE_WORD_W-1:0] mem_word(input logic [`DCACHE_ADDR_W-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr;
    endfunction

    task automatic load_trace(output bit ok);
        int                        fd;
        int                        n;
        string                     line;
        string                     tok;
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_WORD_W-1:0] data;
        ok = 1'b0;
        fd = $fopen("testbench/dcache_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) > 0) begin
            addr = '0;
            data = '0;
            n = $sscanf(line, "%s %h %h", tok, addr, data);
            // Blank and comment lines
            if (n < 2 || tok.getc(0) == "#") begin
                continue;
            end
            op_kind.push_back(tok.getc(0));
            op_addr.push_back(addr);
            op_data.push_back(data);
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    // Responses come back in request order
    task automatic collect_response();
        string                     name;
        logic [`DCACHE_WORD_W-1:0] data;
        bit                        is_load;
        if (resp_valid_o === 1'b1) begin
            if (exp_name.size() == 0) begin
                other_errs++;
                $display("Response seen with no request outstanding");
            end else begin
                name    = exp_name.pop_front();
                data    = exp_data.pop_front();
                is_load = exp_is_load.pop_front();
                if (is_load) begin
                    check_word(name, data, rdata_o);
                end
            end
        end
    endtask

    // ------------------------------
    // Trace replay
    // ------------------------------
    task automatic run_trace();
        int  op_idx;
        bit  drive;
        byte kind;
        op_idx = 0;
        while (op_idx < op_kind.size() || exp_name.size() > 0) begin
            @(negedge clk_i);
            collect_response();
            drive = 1'b0;
            if (op_idx < op_kind.size()) begin
                kind = op_kind[op_idx];
                if (kind == "W") begin
                    // Count once every earlier request has answered
                    if (exp_name.size() == 0) begin
                        check_count($sformatf("writebacks at op %0d", op_idx),
                                    op_addr[op_idx], wb_count);
                        op_idx++;
                    end
                end else if (kind == "L" || kind == "S") begin
                    drive       = 1'b1;
                    req_i       = 1'b1;
                    we_i        = (kind == "S");
                    addr_i.raw  = op_addr[op_idx];
                    wdata_i     = (kind == "S") ? op_data[op_idx] : '0;
                    // gnt_o only moves on the rising edge
                    if (gnt_o) begin
                        exp_is_load.push_back(kind == "L");
                        exp_data.push_back(op_data[op_idx]);
                        exp_name.push_back($sformatf("op %0d %c %h", op_idx, kind,
                                                     op_addr[op_idx]));
                        op_idx++;
                    end
                end else begin
                    other_errs++;
                    $display("Unknown trace operation %c at op %0d", kind, op_idx);
                    op_idx++;
                end
            end
            if (!drive) begin
                req_i = 1'b0;
                we_i  = 1'b0;
            end
        end
        // No stray responses after the last one
        repeat (4) begin
            @(negedge clk_i);
            collect_response();
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    initial begin : memory_model
        cache_addr_u aligned;
        int unsigned delay;
        bit          mem_busy;
        void'($urandom(66995));
        mem_busy = 1'b0;
        delay    = 0;
        forever begin
            @(negedge clk_i);
            if (mem_ack_i) begin
                mem_ack_i = 1'b0;
                mem_busy  = 1'b0;
            end else if (!rst_i && mem_req_o === 1'b1) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    delay    = 1 + ($urandom % 4);
                end
                delay--;
                if (delay == 0) begin
                    aligned.raw = {mem_addr_o.raw[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                                   {`DCACHE_OFFSET_W{1'b0}}};
                    check_addr("memory line address", aligned, mem_addr_o);
                    if (mem_we_o) begin
                        mem_words[mem_addr_o.raw]     = mem_wdata_o[0];
                        mem_words[mem_addr_o.raw + 4] = mem_wdata_o[1];
                        wb_count++;
                    end else begin
                        mem_rdata_i[0] = mem_word(mem_addr_o.raw);
                        mem_rdata_i[1] = mem_word(mem_addr_o.raw + 4);
                    end
                    mem_ack_i = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        bit          trace_ok;
        int unsigned total;
        rst_i       = 1'b1;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Cannot open trace file testbench/dcache_trace.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = 16 + 40 * op_kind.size();
            repeat (16) @(posedge clk_i);
            @(negedge clk_i);
            rst_i = 1'b0;
            run_trace();
            total = word_errs + count_errs + addr_errs + other_errs
                    + dut_i.props_i.assert_fails;
            $display("Errors: word %0d, count %0d, address %0d, assertion %0d, other %0d",
                     word_errs, count_errs, addr_errs, dut_i.props_i.assert_fails, other_errs);
            if (total == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end
endmodule

// ==== testbench/dcache_trace.txt ====
# L addr data: load, data is the expected word; S addr data: store of data
# W count: total memory writebacks expected so far
L 00000100 00000100
W 0
L 00000104 00000104
L 00000310 00000310
L 00000314 00000314
S 00000100 deadbeef
L 00000100 deadbeef
S 00000104 cafef00d
L 00000104 cafef00d
W 0
L 00000900 00000900
W 1
L 00000100 deadbeef
L 00000104 cafef00d
W 1
S 00000248 12345678
L 00000248 12345678
L 0000024c 0000024c
W 1
L 00000a48 00000a48
W 2
L 00000248 12345678
W 2

// ==== project.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_if.sv
hw/line_array.sv
hw/lookup_stage.sv
hw/tag_check_stage.sv
hw/miss_handler.sv
hw/dcache_top.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv
